// ==== routerCore.f ====
design/nocPkg.sv
design/portTimer.sv
design/inputFifo.sv
design/crossbar.sv
design/switchArbiter.sv
design/routerCore.sv
dv/routerCore_assert.sv
dv/routerCoreTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = routerCoreTb
FILELIST = routerCore.f

MDIR     = obj_dir
BIN      = $(MDIR)/V$(TOP)
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)

// ==== dv/routerCoreTb.sv ====
`default_nettype none

module routerCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import nocPkg::*;

  localparam int numPackets = 60;
  localparam int maxCycles  = numPackets * 40 + 200;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  flitT                inFlit [numPorts];
  logic [numPorts-1:0] inFull;
  flitT                outFlit;
  logic                outValid;
  logic [portIdxW-1:0] outPort;

  flitT                model [numPorts][$];   // accepted flits still inside the router
  int                  seed = 54;
  int                  errors = 0;
  int                  delivered = 0;
  int                  dropped = 0;
  int                  sent = 0;
  int                  remaining [numPorts];   // flits left to send in the current packet
  int                  pktLen [numPorts];
  int                  seqNo [numPorts];
  logic [numPorts-1:0] reqD1;
  logic [numPorts-1:0] reqD2;
  logic                outD1;
  logic                outD2;
  logic [portIdxW-1:0] portD1;
  logic [portIdxW-1:0] portD2;

  routerCore uut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inFull   (inFull),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic flitT makeFlit(input int p, input logic [flitIdW-1:0] kind,
                                    input int len, input int seq);
    flitT f;
    f.flitId = kind;
    f.length = lenW'(len);
    f.data   = {4'(p), 12'(seq)};   // source port and sequence number
    return f;
  endfunction

  // first requesting port after the holder, holder itself last
  function automatic logic [portIdxW-1:0] ringNext(input logic [portIdxW-1:0] from,
                                                   input logic [numPorts-1:0] reqs);
    logic [portIdxW-1:0] cand;
    logic [portIdxW-1:0] found;
    found = from;
    for (int k = numPorts; k >= 1; k--)
    begin
      cand = portIdxW'((int'(from) + k) % numPorts);
      if (reqs[cand])
        found = cand;
    end
    return found;
  endfunction

  function automatic logic allIdle();
    for (int p = 0; p < numPorts; p++)
    begin
      if ((remaining[p] != 0) || (model[p].size() != 0))
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic startPacket(input int p, input int len);
    pktLen[p]    = len;
    remaining[p] = len + 1;   // head, bodies and tail
    sent++;
  endtask

  task automatic driveCycle(input logic allowStart);
    logic [flitIdW-1:0] kind;
    for (int p = 0; p < numPorts; p++)
    begin
      inValid[p] = 1'b0;
      // a new packet only once the port has drained
      if (allowStart && (remaining[p] == 0) && (model[p].size() == 0)
          && (sent < numPackets) && (($random(seed) & 3) == 0))
        startPacket(p, 1 + int'($unsigned($random(seed)) % 6));
      if (remaining[p] > 0)
      begin
        if (remaining[p] == pktLen[p] + 1)
          kind = flitHead;
        else if (remaining[p] == 1)
          kind = flitTail;
        else
          kind = flitBody;
        inFlit[p]    = makeFlit(p, kind, pktLen[p], seqNo[p]);
        inValid[p]   = 1'b1;
        seqNo[p]     = seqNo[p] + 1;
        remaining[p] = remaining[p] - 1;
      end
    end
  endtask

  task automatic checkCycle();
    flitT                exp;
    logic [portIdxW-1:0] want;
    logic [numPorts-1:0] reqNow;
    if (outValid)
    begin
      if ((outPort >= numPorts) || (model[outPort].size() == 0))
      begin
        $display("ERR %0t: flit out on port %0d with nothing queued", $time, outPort);
        errors++;
      end
      else
      begin
        exp = model[outPort].pop_front();
        delivered++;
        if (outFlit !== exp)
        begin
          $display("ERR %0t: port %0d got %h, expected %h", $time, outPort, outFlit, exp);
          errors++;
        end
      end
      if (outD1 && (portD1 != outPort))
        want = ringNext(portD1, reqD2);
      else if (!outD1 && outD2)
        want = ringNext(portD2, reqD2);   // holder ran dry one cycle earlier
      else if (!outD1 && !outD2)
        want = ringNext(portS, reqD2);   // from idle, L first
      else
        want = outPort;
      if (want != outPort)
      begin
        $display("ERR %0t: grant went to port %0d, expected %0d", $time, outPort, want);
        errors++;
      end
    end
    for (int p = 0; p < numPorts; p++)
    begin
      reqNow[p] = (model[p].size() != 0);
      if (inFull[p] !== (model[p].size() == fifoDepth))
      begin
        $display("ERR %0t: inFull[%0d] is %b, model holds %0d", $time, p, inFull[p],
                 model[p].size());
        errors++;
      end
      if (inValid[p])
      begin
        if (model[p].size() < fifoDepth)
          model[p].push_back(inFlit[p]);
        else
          dropped++;
      end
    end
    reqD2  = reqD1;
    reqD1  = reqNow;
    outD2  = outD1;
    outD1  = outValid;
    portD2 = portD1;
    portD1 = outPort;
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      checkCycle();
  end

  initial
  begin
    #(maxCycles * 20);
    $display("run did not finish within %0d cycles", maxCycles);
    $display("test failed");
    $finish;
  end

  initial
  begin
    rst     = 1'b1;
    inValid = '0;
    reqD1   = '0;
    reqD2   = '0;
    outD1   = 1'b0;
    outD2   = 1'b0;
    portD1  = '0;
    portD2  = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]    = '0;
      remaining[p] = 0;
      pktLen[p]    = 0;
      seqNo[p]     = 0;
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    repeat (3) @(posedge clk);

    // all five ports at once, the waiting ones overflow
    for (int p = 0; p < numPorts; p++)
      startPacket(p, 6);
    do
    begin
      @(posedge clk);
      #1;
      driveCycle(1'b0);
    end while (!allIdle());

    while (!((sent == numPackets) && allIdle()))
    begin
      @(posedge clk);
      #1;
      driveCycle(1'b1);
    end
    repeat (5) @(posedge clk);

    $display("errors: scoreboard %0d, assertions %0d; flits out %0d, dropped %0d",
             errors, uut.uAssert.failCount, delivered, dropped);
    if ((errors == 0) && (uut.uAssert.failCount == 0))
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/routerCore_assert.sv ====
`default_nettype none

module routerCore_assert (
  input logic                        clk,
  input logic                        rst,
  input nocPkg::grantT               grant,
  input logic [nocPkg::numPorts-1:0] req,
  input logic [nocPkg::numPorts-1:0] popped,
  input nocPkg::flitT                headFlit [nocPkg::numPorts],
  input logic [nocPkg::numPorts-1:0] inFull,
  input logic                        outValid,
  input logic [nocPkg::portIdxW-1:0] outPort
);
  timeunit 1ns;
  timeprecision 1ps;
  import nocPkg::*;

  int              failCount = 0;
  logic [lenW-1:0] lastLen [numPorts];   // length of the last head popped per port
  logic [lenW-1:0] effLimit;
  logic [lenW-1:0] holdCnt;
  logic [lenW-1:0] prevCnt;
  grantT           prevGrant;
  logic            prevOthers;
  logic            others;

  assign others = ((req & ~grant) != '0);

  // cycles already held while some other port was waiting
  assign holdCnt = ((grant != '0) && (grant == prevGrant) && prevOthers) ? prevCnt + 1'b1 : '0;

  always_comb
  begin
    effLimit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        effLimit = (popped[i] && (headFlit[i].flitId == flitHead)) ? headFlit[i].length
                                                                   : lastLen[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prevGrant  <= '0;
      prevOthers <= 1'b0;
      prevCnt    <= '0;
      for (int i = 0; i < numPorts; i++)
        lastLen[i] <= '0;
    end
    else
    begin
      prevGrant  <= grant;
      prevOthers <= others;
      prevCnt    <= holdCnt;
      for (int i = 0; i < numPorts; i++)
      begin
        if (popped[i] && (headFlit[i].flitId == flitHead))
          lastLen[i] <= headFlit[i].length;
      end
    end
  end

  resetState: assert property (@(posedge clk)
    $past(rst) |-> (grant == '0) && !outValid && (inFull == '0))
    else begin $error("link or buffers not idle after reset"); failCount = failCount + 1; end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else begin $error("grant is not one-hot"); failCount = failCount + 1; end

  validAfterPop: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (outValid == $past(|popped)))
    else begin $error("outValid does not follow the pop"); failCount = failCount + 1; end

  portAfterPop: assert property (@(posedge clk) disable iff (rst)
    (|popped) |=> ($past(popped) == (grantT'(1) << outPort)))
    else begin $error("outPort differs from popped port"); failCount = failCount + 1; end

  idleWithoutReq: assert property (@(posedge clk) disable iff (rst)
    (req == '0) |=> (grant == '0))
    else begin $error("grant kept with no requests"); failCount = failCount + 1; end

  holdLimit: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) |-> (holdCnt <= effLimit))
    else begin $error("port held the link past its length"); failCount = failCount + 1; end

endmodule

bind routerCore routerCore_assert uAssert (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .req      (req),
  .popped   (popped),
  .headFlit (headFlit),
  .inFull   (inFull),
  .outValid (outValid),
  .outPort  (outPort)
);

`default_nettype wire

// ==== design/routerCore.sv ====
`default_nettype none

module routerCore (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  nocPkg::flitT                inFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inFull,
  output nocPkg::flitT                outFlit,
  output logic                        outValid,
  output logic [nocPkg::portIdxW-1:0] outPort
);
  import nocPkg::*;

  logic [numPorts-1:0] req;
  logic [numPorts-1:0] popped;
  flitT                headFlit [numPorts];
  grantT               grant;

  for (genvar p = 0; p < numPorts; p++)
  begin : genPort
    inputFifo uFifo (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inFlit   (inFlit[p]),
      .grantMe  (grant[p]),
      .headFlit (headFlit[p]),
      .popped   (popped[p]),
      .notEmpty (req[p]),   // request is simply a non-empty buffer
      .full     (inFull[p])
    );
  end

  switchArbiter uArb (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .popped   (popped),
    .headFlit (headFlit),
    .grant    (grant)
  );

  crossbar uXbar (
    .clk      (clk),
    .rst      (rst),
    .popped   (popped),
    .headFlit (headFlit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

// ==== design/switchArbiter.sv ====
`default_nettype none

module switchArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] req,
  input  logic [nocPkg::numPorts-1:0] popped,
  input  nocPkg::flitT                headFlit [nocPkg::numPorts],
  output nocPkg::grantT               grant
);
  import nocPkg::*;

  grantT               nextGrant;
  logic [numPorts-1:0] headLoad;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  logic [portIdxW-1:0] holder;
  logic [portIdxW-1:0] cand;
  logic                keep;

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    assign headLoad[p] = popped[p] && (headFlit[p].flitId == flitHead);

    portTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .load       (headLoad[p]),
      .loadLength (headFlit[p].length),
      .run        (runTimer[p]),
      .timesUp    (timesUp[p])
    );
  end

  // from idle pretend S held last, so the ring search starts at L
  always_comb
  begin
    holder = portS;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        holder = portIdxW'(i);
    end
  end

  assign keep = (grant != '0) && req[holder] && !timesUp[holder];

  always_comb
  begin
    nextGrant = '0;
    runTimer  = '0;
    cand      = holder;
    if (keep)
    begin
      nextGrant = grant;
      runTimer  = grant;   // only the holder that keeps the link counts
    end
    else
    begin
      // rotate from the port after the holder, holder itself comes last
      for (int k = 0; k < numPorts; k++)
      begin
        cand = (cand == portIdxW'(numPorts - 1)) ? '0 : cand + 1'b1;
        if ((nextGrant == '0) && req[cand])
          nextGrant[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= '0;
    else
      grant <= nextGrant;   // no requests gives all zero, back to idle
  end

endmodule

`default_nettype wire

// ==== design/crossbar.sv ====
`default_nettype none

module crossbar (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] popped,
  input  nocPkg::flitT                headFlit [nocPkg::numPorts],
  output nocPkg::flitT                outFlit,
  output logic                        outValid,
  output logic [nocPkg::portIdxW-1:0] outPort
);
  import nocPkg::*;

  logic [portIdxW-1:0] sel;

  // pops are one-hot since they follow the grant
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (popped[i])
        sel = portIdxW'(i);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |popped;
  end

  always_ff @(posedge clk)
  begin
    if (|popped)
    begin
      outFlit <= headFlit[sel];
      outPort <= sel;   // source port travels with the flit
    end
  end

endmodule

`default_nettype wire

// ==== design/inputFifo.sv ====
`default_nettype none

module inputFifo (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  input  nocPkg::flitT inFlit,
  input  logic         grantMe,
  output nocPkg::flitT headFlit,
  output logic         popped,
  output logic         notEmpty,
  output logic         full
);
  import nocPkg::*;

  flitT                mem [fifoDepth];
  logic [fifoPtrW-1:0] wrPtr;
  logic [fifoPtrW-1:0] rdPtr;
  logic [fifoPtrW:0]   count;
  logic                push;

  assign full     = (count == (fifoPtrW + 1)'(fifoDepth));
  assign notEmpty = (count != '0);
  assign push     = inValid && !full;   // a flit arriving at a full buffer is lost
  assign popped   = grantMe && notEmpty;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;   // depth is a power of two, pointers wrap
      if (popped)
        rdPtr <= rdPtr + 1'b1;
      case ({push, popped})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/portTimer.sv ====
`default_nettype none

module portTimer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load,
  input  logic [nocPkg::lenW-1:0] loadLength,
  input  logic                    run,
  output logic                    timesUp
);
  import nocPkg::*;

  logic [lenW-1:0] limit;   // hold limit from the last head flit
  logic [lenW-1:0] count;   // cycles held so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= loadLength;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;   // restart whenever the hold breaks
    end
  end

  // a head popped on the first grant cycle must not be judged against the old limit
  assign timesUp = (count == (load ? loadLength : limit));

endmodule

`default_nettype wire

// ==== design/nocPkg.sv ====
`default_nettype none

package nocPkg;

  localparam int numPorts  = 5;
  localparam int portIdxW  = 3;
  localparam int flitIdW   = 3;
  localparam int lenW      = 12;
  localparam int dataW     = 16;
  localparam int fifoDepth = 4;
  localparam int fifoPtrW  = $clog2(fifoDepth);

  // flit kinds, only a head flit loads the hold timer
  localparam logic [flitIdW-1:0] flitHead = 3'd1;
  localparam logic [flitIdW-1:0] flitBody = 3'd2;
  localparam logic [flitIdW-1:0] flitTail = 3'd3;

  // port indices, also bit positions in the one-hot grant
  localparam logic [portIdxW-1:0] portL = 3'd0;
  localparam logic [portIdxW-1:0] portN = 3'd1;
  localparam logic [portIdxW-1:0] portE = 3'd2;
  localparam logic [portIdxW-1:0] portW = 3'd3;
  localparam logic [portIdxW-1:0] portS = 3'd4;

  typedef struct packed {
    logic [flitIdW-1:0] flitId;
    logic [lenW-1:0]    length;   // packet length, meaningful in head flits
    logic [dataW-1:0]   data;
  } flitT;

  typedef logic [numPorts-1:0] grantT;   // one-hot, all zero when idle

endpackage

`default_nettype wire
